//--- design/core_cfg_pkg.sv
// core sizing for an RV64 integer pipeline; register count and index width must stay consistent
package core_cfg_pkg;

    // integer data path width, RV64
    localparam int XLEN = 64;

    // architectural integer registers x0..x31
    localparam int NUM_REGS = 32;

    // bits needed to name one register
    // must satisfy 2**REG_ADDR_W == NUM_REGS
    localparam int REG_ADDR_W = 5;

endpackage

//--- design/rv_isa_pkg.sv
// RV64IM base encodings only; compressed and floating point formats are not described
package rv_isa_pkg;

    // fixed 32-bit instruction word, no RVC
    localparam int INSTR_W = 32;

    // operation key is {funct3, opcode}
    localparam int OP_KEY_W = 10;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_FENCE     = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // immediate format select, decoder to imm_gen
    localparam int IMM_FMT_W = 3;

    // no immediate, imm_gen returns zero
    localparam logic [IMM_FMT_W-1:0] FMT_NONE = 3'd0;
    localparam logic [IMM_FMT_W-1:0] FMT_I    = 3'd1;
    localparam logic [IMM_FMT_W-1:0] FMT_S    = 3'd2;
    localparam logic [IMM_FMT_W-1:0] FMT_B    = 3'd3;
    localparam logic [IMM_FMT_W-1:0] FMT_U    = 3'd4;
    localparam logic [IMM_FMT_W-1:0] FMT_J    = 3'd5;

    // one instruction word seen through each base format
    // opcode sits in bits 6:0 in every view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        // branch offset bits are scattered, bit 0 implied
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        // jump offset, bit 0 implied
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

//--- design/instr_decoder.sv
// opcode and funct3 only; funct7 is never checked so reserved encodings inside a class pass
`timescale 1ns/100ps

module instr_decoder (
    input  logic [rv_isa_pkg::INSTR_W-1:0]    instr,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_isa_pkg::OP_KEY_W-1:0]   op_key,
    output logic [rv_isa_pkg::IMM_FMT_W-1:0]  imm_fmt,
    output logic                              illegal
);
    import rv_isa_pkg::*;

    instr_u word;

    assign word = instr;

    always_comb begin
        // defaults match the unknown opcode case
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        op_key  = '0;
        imm_fmt = FMT_NONE;
        illegal = 1'b0;
        case (word.r.opcode)
            // register-register, no immediate
            OPC_OP, OPC_OP_32: begin
                rs1    = word.r.rs1;
                rs2    = word.r.rs2;
                rd     = word.r.rd;
                op_key = {word.r.funct3, word.r.opcode};
            end
            OPC_STORE: begin
                rs1     = word.s.rs1;
                rs2     = word.s.rs2;
                op_key  = {word.s.funct3, word.s.opcode};
                imm_fmt = FMT_S;
            end
            OPC_BRANCH: begin
                rs1     = word.b.rs1;
                rs2     = word.b.rs2;
                op_key  = {word.b.funct3, word.b.opcode};
                imm_fmt = FMT_B;
            end
            // single source plus 12-bit immediate
            OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_SYSTEM: begin
                rs1     = word.i.rs1;
                rd      = word.i.rd;
                op_key  = {word.i.funct3, word.i.opcode};
                imm_fmt = FMT_I;
            end
            // funct3 carries no meaning for jalr
            OPC_JALR: begin
                rs1     = word.i.rs1;
                rd      = word.i.rd;
                op_key  = {3'b000, word.i.opcode};
                imm_fmt = FMT_I;
            end
            OPC_LUI, OPC_AUIPC: begin
                rd      = word.u.rd;
                op_key  = {3'b000, word.u.opcode};
                imm_fmt = FMT_U;
            end
            OPC_JAL: begin
                rd      = word.j.rd;
                op_key  = {3'b000, word.j.opcode};
                imm_fmt = FMT_J;
            end
            // fence and fence.i, ordering bits ride in the immediate
            OPC_FENCE: begin
                op_key  = {word.i.funct3, word.i.opcode};
                imm_fmt = FMT_I;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- design/imm_gen.sv
// all immediates sign-extend from instr[31]; shift amounts are not masked out of the I form
`timescale 1ns/100ps

module imm_gen (
    input  logic [rv_isa_pkg::INSTR_W-1:0]   instr,
    input  logic [rv_isa_pkg::IMM_FMT_W-1:0] imm_fmt,
    output logic [core_cfg_pkg::XLEN-1:0]    imm
);
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    instr_u word;

    assign word = instr;

    always_comb begin
        case (imm_fmt)
            // 12-bit signed
            FMT_I: imm = {{(XLEN-12){word.i.imm_11_0[11]}}, word.i.imm_11_0};
            // store offset split around rs2/rs1
            FMT_S: imm = {{(XLEN-12){word.s.imm_11_5[6]}}, word.s.imm_11_5, word.s.imm_4_0};
            // 13-bit branch offset, even
            FMT_B: imm = {{(XLEN-13){word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                          word.b.imm_10_5, word.b.imm_4_1, 1'b0};
            // upper 20 bits, low 12 cleared
            FMT_U: imm = {{(XLEN-32){word.u.imm_31_12[19]}}, word.u.imm_31_12, 12'b0};
            // 21-bit jump offset, even
            FMT_J: imm = {{(XLEN-21){word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                          word.j.imm_11, word.j.imm_10_1, 1'b0};
            // FMT_NONE and unused codes
            default: imm = '0;
        endcase
    end

endmodule

//--- design/reg_file.sv
// one write port with no stall; a write in flight is forwarded to both reads, x0 is hardwired
`timescale 1ns/100ps

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2,
    input  logic                                wr_en,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [core_cfg_pkg::XLEN-1:0]       wr_data,
    output logic [core_cfg_pkg::XLEN-1:0]       rs1_data,
    output logic [core_cfg_pkg::XLEN-1:0]       rs2_data
);
    import core_cfg_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // shared by both read ports
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0)
            val = '0;
        // bypass the write landing on this edge
        else if (wr_en && (wr_addr == idx))
            val = wr_data;
        else
            val = regs[idx];
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end
        // x0 never written
        else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, forwarding included
    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

//--- design/decode_out_reg.sv
// single-entry skid-free stage; in_ready depends combinationally on out_ready
`timescale 1ns/100ps

module decode_out_reg (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  logic                                out_ready,
    input  logic [core_cfg_pkg::XLEN-1:0]       rs1_data,
    input  logic [core_cfg_pkg::XLEN-1:0]       rs2_data,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd,
    input  logic [core_cfg_pkg::XLEN-1:0]       imm,
    input  logic [rv_isa_pkg::OP_KEY_W-1:0]     op_key,
    input  logic [core_cfg_pkg::XLEN-1:0]       pc,
    input  logic                                illegal,
    output logic                                in_ready,
    output logic                                out_valid,
    output logic [core_cfg_pkg::XLEN-1:0]       out_rs1_data,
    output logic [core_cfg_pkg::XLEN-1:0]       out_rs2_data,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] out_rd,
    output logic [core_cfg_pkg::XLEN-1:0]       out_imm,
    output logic [rv_isa_pkg::OP_KEY_W-1:0]     out_op_key,
    output logic [core_cfg_pkg::XLEN-1:0]       out_pc,
    output logic                                out_illegal
);

    logic load;

    // empty, or current item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    // occupancy
    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    // payload only moves on an accepted transfer
    // held unchanged while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            out_rs1_data <= rs1_data;
            out_rs2_data <= rs2_data;
            out_rd       <= rd;
            out_imm      <= imm;
            out_op_key   <= op_key;
            out_pc       <= pc;
            out_illegal  <= illegal;
        end
    end

endmodule

//--- design/decode_top.sv
// decode stage, one cycle latency, holds one item; write-back port has no handshake
`timescale 1ns/100ps

module decode_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic [rv_isa_pkg::INSTR_W-1:0]      in_instr,
    input  logic [core_cfg_pkg::XLEN-1:0]       in_pc,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [core_cfg_pkg::XLEN-1:0]       out_rs1_data,
    output logic [core_cfg_pkg::XLEN-1:0]       out_rs2_data,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] out_rd,
    output logic [core_cfg_pkg::XLEN-1:0]       out_imm,
    output logic [rv_isa_pkg::OP_KEY_W-1:0]     out_op_key,
    output logic [core_cfg_pkg::XLEN-1:0]       out_pc,
    output logic                                out_illegal,
    input  logic                                wr_en,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [core_cfg_pkg::XLEN-1:0]       wr_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // decoder fields
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [OP_KEY_W-1:0]   dec_op_key;
    logic [IMM_FMT_W-1:0]  dec_imm_fmt;
    logic                  dec_illegal;
    // operand values ahead of the stage register
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;

    instr_decoder u_instr_decoder (
        .instr   (in_instr),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .rd      (dec_rd),
        .op_key  (dec_op_key),
        .imm_fmt (dec_imm_fmt),
        .illegal (dec_illegal)
    );

    imm_gen u_imm_gen (
        .instr   (in_instr),
        .imm_fmt (dec_imm_fmt),
        .imm     (imm)
    );

    // indices come straight from the decoder, reads are combinational
    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // pc bypasses the decode logic
    decode_out_reg u_decode_out_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .out_ready    (out_ready),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd           (dec_rd),
        .imm          (imm),
        .op_key       (dec_op_key),
        .pc           (in_pc),
        .illegal      (dec_illegal),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_rs1_data (out_rs1_data),
        .out_rs2_data (out_rs2_data),
        .out_rd       (out_rd),
        .out_imm      (out_imm),
        .out_op_key   (out_op_key),
        .out_pc       (out_pc),
        .out_illegal  (out_illegal)
    );

endmodule

//--- tb/tb_decode_ref.svh
// include inside the testbench module after both package imports and the seed variable
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// one expected output item
typedef struct packed {
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic [OP_KEY_W-1:0]   op_key;
    logic [XLEN-1:0]       pc;
    logic                  illegal;
} exp_rec_t;

// the thirteen known major opcodes
localparam logic [6:0] KNOWN_OPC [13] = '{OPC_OP, OPC_OP_32, OPC_LOAD, OPC_OP_IMM,
    OPC_OP_IMM_32, OPC_JALR, OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_AUIPC, OPC_JAL,
    OPC_FENCE, OPC_SYSTEM};

// mirror of the register file, follows every driven write
logic [XLEN-1:0] shadow_regs [NUM_REGS];

// x0 reads zero, a write landing on the sampling edge wins
function automatic logic [XLEN-1:0] shadow_read(input logic [REG_ADDR_W-1:0] idx,
    input logic we, input logic [REG_ADDR_W-1:0] wa, input logic [XLEN-1:0] wd);
    if (idx == '0)
        return '0;
    if (we && (wa == idx))
        return wd;
    return shadow_regs[idx];
endfunction

function automatic exp_rec_t ref_decode(input logic [INSTR_W-1:0] ins,
    input logic [XLEN-1:0] pc, input logic we, input logic [REG_ADDR_W-1:0] wa,
    input logic [XLEN-1:0] wd);
    exp_rec_t e;
    // {known, reads rs1, reads rs2, writes rd, funct3 in key, immediate format}
    logic [7:0] sel;
    case (ins[6:0])
        OPC_OP, OPC_OP_32:   sel = {5'b11111, FMT_NONE};
        OPC_STORE:           sel = {5'b11101, FMT_S};
        OPC_BRANCH:          sel = {5'b11101, FMT_B};
        OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_SYSTEM: sel = {5'b11011, FMT_I};
        OPC_JALR:            sel = {5'b11010, FMT_I};
        OPC_LUI, OPC_AUIPC:  sel = {5'b10010, FMT_U};
        OPC_JAL:             sel = {5'b10010, FMT_J};
        OPC_FENCE:           sel = {5'b10001, FMT_I};
        default:             sel = {5'b00000, FMT_NONE};
    endcase
    e          = '0;
    e.pc       = pc;
    e.illegal  = !sel[7];
    e.rs1_data = sel[6] ? shadow_read(ins[19:15], we, wa, wd) : '0;
    e.rs2_data = sel[5] ? shadow_read(ins[24:20], we, wa, wd) : '0;
    e.rd       = sel[4] ? ins[11:7] : '0;
    e.op_key   = sel[7] ? {(sel[3] ? ins[14:12] : 3'b000), ins[6:0]} : '0;
    // sign always from bit 31, B and J offsets even
    case (sel[2:0])
        FMT_I:   e.imm = {{52{ins[31]}}, ins[31:20]};
        FMT_S:   e.imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        FMT_B:   e.imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        FMT_U:   e.imm = {{32{ins[31]}}, ins[31:12], 12'h000};
        FMT_J:   e.imm = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        default: e.imm = '0;
    endcase
    return e;
endfunction

// random word with a known opcode
function automatic logic [INSTR_W-1:0] gen_legal();
    logic [INSTR_W-1:0] w;
    int cls;
    w      = $random(seed);
    cls    = $unsigned($random(seed)) % 13;
    w[6:0] = KNOWN_OPC[cls];
    return w;
endfunction

// random word whose opcode is outside the known set
function automatic logic [INSTR_W-1:0] gen_illegal();
    logic [INSTR_W-1:0] w;
    logic hit;
    w = $random(seed);
    do begin
        w[6:0] = 7'($random(seed));
        hit    = 1'b0;
        foreach (KNOWN_OPC[k])
            if (KNOWN_OPC[k] == w[6:0])
                hit = 1'b1;
    end while (hit);
    return w;
endfunction

`endif

//--- tb/tb_decode_top.sv
// needs timing support for delays; stops at the first mismatch, stimulus from a fixed seed
`timescale 1ns/100ps

module tb_decode_top;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // cold 16, write mix 200, directed 3, stall mix 200, unknown opcodes 50
    localparam int N_TOTAL        = 16 + 200 + 3 + 200 + 50;
    localparam int TIMEOUT_CYCLES = N_TOTAL * 8 + 100;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    logic [INSTR_W-1:0]    in_instr;
    logic [XLEN-1:0]       in_pc;
    logic                  out_valid;
    logic                  out_ready;
    logic [XLEN-1:0]       out_rs1_data;
    logic [XLEN-1:0]       out_rs2_data;
    logic [REG_ADDR_W-1:0] out_rd;
    logic [XLEN-1:0]       out_imm;
    logic [OP_KEY_W-1:0]   out_op_key;
    logic [XLEN-1:0]       out_pc;
    logic                  out_illegal;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;
    integer                seed;
    // per-cycle random modes
    logic                  rand_writes;
    logic                  rand_ready;
    logic                  stalled = 1'b0;
    // transfer seen on the input side last cycle
    logic                  accepted = 1'b0;

    `include "tb_decode_ref.svh"

    // accepted but not yet seen at the output, oldest first
    exp_rec_t exp_q[$];

    // all ports match by name
    decode_top u_decode_top (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected)
            report_failure($sformatf("** Error %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic compare_outputs(input exp_rec_t e);
        check_value("out_rs1_data", e.rs1_data, out_rs1_data);
        check_value("out_rs2_data", e.rs2_data, out_rs2_data);
        check_value("out_rd", 64'(e.rd), 64'(out_rd));
        check_value("out_imm", e.imm, out_imm);
        check_value("out_op_key", 64'(e.op_key), 64'(out_op_key));
        check_value("out_pc", e.pc, out_pc);
        check_value("out_illegal", 64'(e.illegal), 64'(out_illegal));
    endtask

    // write port and out_ready change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
        wr_en     = rand_writes && (($random(seed) & 3) == 0);
        wr_addr   = 5'($random(seed));
        wr_data   = {$random(seed), $random(seed)};
        out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
    endtask

    // valid and payload held until in_ready is seen mid-cycle
    task automatic send_instr(input logic [INSTR_W-1:0] instr, input logic [XLEN-1:0] pc);
        logic taken;
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    // expected side, inputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            foreach (shadow_regs[k])
                shadow_regs[k] = '0;
        end else begin
            if (in_valid && in_ready)
                exp_q.push_back(ref_decode(in_instr, in_pc, wr_en, wr_addr, wr_data));
            if (wr_en && (wr_addr != '0))
                shadow_regs[wr_addr] = wr_data;
        end
    end

    // output side, head of queue must be on the outputs for every valid cycle
    always @(negedge clk) begin : compare_proc
        logic was_stalled;
        logic was_accepted;
        was_stalled  = stalled;
        was_accepted = accepted;
        stalled      = out_valid && !out_ready;
        accepted     = in_valid && in_ready;
        if (!reset) begin
            if (was_accepted && !out_valid)
                report_failure("out_valid not raised one cycle after an accepted instruction");
            else if (was_stalled && !out_valid)
                report_failure("out_valid dropped while the output was stalled");
            // empty stage takes input
            else if (!out_valid)
                check_value("in_ready", 64'd1, 64'(in_ready));
            else if (exp_q.size() == 0)
                report_failure("output valid with no accepted instruction pending");
            else begin
                compare_outputs(exp_q[0]);
                // old item leaves, new one may enter on the same edge
                if (out_ready) begin
                    void'(exp_q.pop_front());
                    check_value("in_ready", 64'd1, 64'(in_ready));
                end else
                    check_value("in_ready", '0, 64'(in_ready));
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        seed        = 32'h85;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_instr    = '0;
        in_pc       = '0;
        out_ready   = 1'b1;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        rand_writes = 1'b0;
        rand_ready  = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        // empty stage straight after reset
        @(negedge clk);
        check_value("out_valid", '0, 64'(out_valid));
        check_value("in_ready", 64'd1, 64'(in_ready));
        next_cycle();
        // nothing written yet, every read is zero
        repeat (16) send_instr(gen_legal(), {$random(seed), $random(seed)});
        rand_writes = 1'b1;
        repeat (200) send_instr(gen_legal(), {$random(seed), $random(seed)});
        // x0 write on the accepting edge, add x1, x0, x0
        rand_writes = 1'b0;
        wr_en       = 1'b1;
        wr_addr     = '0;
        wr_data     = '1;
        send_instr({7'h00, 5'd0, 5'd0, 3'b000, 5'd1, OPC_OP}, 64'h100);
        // same-edge write to x7 forwarded to both ports
        wr_en   = 1'b1;
        wr_addr = 5'd7;
        wr_data = 64'hdead_beef_0bad_f00d;
        send_instr({7'h00, 5'd7, 5'd7, 3'b000, 5'd2, OPC_OP}, 64'h104);
        send_instr({7'h12, 5'd0, 5'd7, 3'b011, 5'h0a, OPC_STORE}, 64'h108);
        // random back-pressure and input gaps
        rand_writes = 1'b1;
        rand_ready  = 1'b1;
        repeat (200) begin
            if (($random(seed) & 3) == 0)
                next_cycle();
            send_instr(gen_legal(), {$random(seed), $random(seed)});
        end
        repeat (50) send_instr(gen_illegal(), {$random(seed), $random(seed)});
        // drain
        rand_ready = 1'b0;
        out_ready  = 1'b1;
        while (out_valid)
            next_cycle();
        @(negedge clk);
        if (exp_q.size() != 0)
            report_failure($sformatf("%0d accepted instructions never left", exp_q.size()));
        else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+tb
design/core_cfg_pkg.sv
design/rv_isa_pkg.sv
design/instr_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/decode_out_reg.sv
design/decode_top.sv
tb/tb_decode_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_decode_top
SEED      ?= 1
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

FILELIST := project.f
SOURCES  := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard tb/*.svh)
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Done: errors found" $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
